// ==== riscv_types_pkg.sv ====
//======================================================================
// Branch predictor shared types
//======================================================================

package riscv_types_pkg;

    // Instruction address
    typedef logic [31:0] addr_t;

    // 35-bit resolved branch from the retire stage
    typedef struct packed {
        logic  update_valid;
        logic  is_branch;
        logic  actual_taken;
        addr_t update_pc;
    } branch_update_t;

    // Final prediction toward fetch
    typedef struct packed {
        logic taken;
        logic used_global;
    } prediction_t;

    // 2-bit saturating counter encodings
    localparam logic [1:0] CNT_STRONG_NT  = 2'b00;
    localparam logic [1:0] CNT_WEAK_NT    = 2'b01;
    localparam logic [1:0] CNT_STRONG_T   = 2'b11;
    // Chooser upper bit set selects global
    localparam logic [1:0] CNT_WEAK_LOCAL = 2'b01;

    // Saturating step that counts up when inc is set
    function automatic logic [1:0] cnt_next(input logic [1:0] cnt, input logic inc);
        if (inc) begin
            return (cnt == CNT_STRONG_T) ? cnt : cnt + 2'd1;
        end
        return (cnt == CNT_STRONG_NT) ? cnt : cnt - 2'd1;
    endfunction

endpackage : riscv_types_pkg

// ==== global_predictor.sv ====
//======================================================================
// Gshare global predictor
//======================================================================

`timescale 1ns/1ns

module global_predictor #(
    parameter int GLOBAL_HISTORY_WIDTH = 8,
    parameter int PHT_ENTRIES          = 256
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // Lookup side
    input  riscv_types_pkg::addr_t          pc_i,
    output logic                            predict_taken_o,
    // Training side
    input  riscv_types_pkg::branch_update_t update_i,
    output logic                            update_pred_o
);

    localparam int PHT_IDX_W = $clog2(PHT_ENTRIES);
    // Table must be a full power of two and wide enough for the history
    localparam bit SIZES_OK = ((1 << PHT_IDX_W) == PHT_ENTRIES) &&
                              (PHT_IDX_W >= GLOBAL_HISTORY_WIDTH);

    logic [GLOBAL_HISTORY_WIDTH-1:0] ghr_r;
    logic [1:0]                      pht_r [PHT_ENTRIES];

    logic                 apply_c;
    logic [PHT_IDX_W-1:0] ghr_ext_c;
    logic [PHT_IDX_W-1:0] pred_idx_c;
    logic [PHT_IDX_W-1:0] upd_idx_c;

    //==================================================================
    // Indexing
    //==================================================================

    assign apply_c   = update_i.update_valid && update_i.is_branch;
    // History zero-extended to the table index
    assign ghr_ext_c = PHT_IDX_W'(ghr_r);

    // Word-aligned PC bits folded with history
    assign pred_idx_c = ghr_ext_c ^ pc_i[PHT_IDX_W+1:2];
    assign upd_idx_c  = ghr_ext_c ^ update_i.update_pc[PHT_IDX_W+1:2];

    // Upper counter bit is the opinion
    assign predict_taken_o = pht_r[pred_idx_c][1];
    assign update_pred_o   = pht_r[upd_idx_c][1];

    //==================================================================
    // Training
    //==================================================================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_r <= '0;
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_r[i] <= riscv_types_pkg::CNT_WEAK_NT;
            end
        end else if (apply_c) begin
            // Shift in newest outcome at the bottom
            ghr_r <= {ghr_r[GLOBAL_HISTORY_WIDTH-2:0], update_i.actual_taken};
            pht_r[upd_idx_c] <= riscv_types_pkg::cnt_next(pht_r[upd_idx_c],
                                                          update_i.actual_taken);
        end
    end

    // Sizing holds for the whole run
    a_sizes_ok: assert property (@(posedge clk_i) SIZES_OK);

    // Table contents stay known after reset
    a_pred_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(predict_taken_o));

endmodule : global_predictor

// ==== local_predictor.sv ====
//======================================================================
// Per-PC local history predictor
//======================================================================

`timescale 1ns/1ns

module local_predictor #(
    parameter int LOCAL_HISTORY_WIDTH = 6,
    parameter int LHT_ENTRIES         = 64
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // Lookup side
    input  riscv_types_pkg::addr_t          pc_i,
    output logic                            predict_taken_o,
    // Training side
    input  riscv_types_pkg::branch_update_t update_i,
    output logic                            update_pred_o
);

    localparam int LHT_IDX_W    = $clog2(LHT_ENTRIES);
    // One counter per possible history pattern
    localparam int LPHT_ENTRIES = 1 << LOCAL_HISTORY_WIDTH;
    localparam int FLAT_W       = LHT_ENTRIES * LOCAL_HISTORY_WIDTH;

    logic [LOCAL_HISTORY_WIDTH-1:0] lht_r  [LHT_ENTRIES];
    logic [1:0]                     lpht_r [LPHT_ENTRIES];

    logic                           apply_c;
    logic [LHT_IDX_W-1:0]           pred_idx_c;
    logic [LHT_IDX_W-1:0]           upd_idx_c;
    logic [LOCAL_HISTORY_WIDTH-1:0] pred_hist_c;
    logic [LOCAL_HISTORY_WIDTH-1:0] upd_hist_c;
    logic [LOCAL_HISTORY_WIDTH-1:0] upd_hist_next_c;
    logic [FLAT_W-1:0]              lht_flat_c;

    assign apply_c = update_i.update_valid && update_i.is_branch;

    //==================================================================
    // Two-level lookup
    //==================================================================

    // PC modulo table size selects the history entry
    assign pred_idx_c = pc_i[LHT_IDX_W+1:2];
    assign upd_idx_c  = update_i.update_pc[LHT_IDX_W+1:2];

    // History then selects the counter
    assign pred_hist_c = lht_r[pred_idx_c];
    assign upd_hist_c  = lht_r[upd_idx_c];

    assign predict_taken_o = lpht_r[pred_hist_c][1];
    assign update_pred_o   = lpht_r[upd_hist_c][1];

    assign upd_hist_next_c = {upd_hist_c[LOCAL_HISTORY_WIDTH-2:0], update_i.actual_taken};

    //==================================================================
    // Training
    //==================================================================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < LHT_ENTRIES; i++) begin
                lht_r[i] <= '0;
            end
            for (int j = 0; j < LPHT_ENTRIES; j++) begin
                lpht_r[j] <= riscv_types_pkg::CNT_WEAK_NT;
            end
        end else if (apply_c) begin
            // Counter trained under the pre-edge history
            lpht_r[upd_hist_c] <= riscv_types_pkg::cnt_next(lpht_r[upd_hist_c],
                                                            update_i.actual_taken);
            lht_r[upd_idx_c]   <= upd_hist_next_c;
        end
    end

    // Flattened view of the history table for checking
    always_comb begin
        for (int i = 0; i < LHT_ENTRIES; i++) begin
            lht_flat_c[i*LOCAL_HISTORY_WIDTH +: LOCAL_HISTORY_WIDTH] = lht_r[i];
        end
    end

    // Entries that differ between two snapshots
    function automatic int unsigned count_changed(input logic [FLAT_W-1:0] a,
                                                  input logic [FLAT_W-1:0] b);
        int unsigned n;
        n = 0;
        for (int i = 0; i < LHT_ENTRIES; i++) begin
            if (a[i*LOCAL_HISTORY_WIDTH +: LOCAL_HISTORY_WIDTH] !=
                b[i*LOCAL_HISTORY_WIDTH +: LOCAL_HISTORY_WIDTH]) begin
                n++;
            end
        end
        return n;
    endfunction

    // At most one history entry changes per applied update
    a_one_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
        apply_c |=> (count_changed(lht_flat_c, $past(lht_flat_c)) <= 1));

endmodule : local_predictor

// ==== tournament_chooser.sv ====
//======================================================================
// Tournament selector table
//======================================================================

`timescale 1ns/1ns

module tournament_chooser #(
    parameter int CHOOSER_ENTRIES = 64
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  riscv_types_pkg::addr_t          pc_i,
    input  riscv_types_pkg::branch_update_t update_i,
    // Opinions for the lookup PC
    input  logic                            global_pred_i,
    input  logic                            local_pred_i,
    // Opinions for the update PC
    input  logic                            global_update_pred_i,
    input  logic                            local_update_pred_i,
    output logic                            use_global_o
);

    localparam int CH_IDX_W = $clog2(CHOOSER_ENTRIES);

    logic [1:0] chooser_r [CHOOSER_ENTRIES];

    logic                      apply_c;
    logic                      train_c;
    logic                      global_right_c;
    logic [CH_IDX_W-1:0]       pred_idx_c;
    logic [CH_IDX_W-1:0]       upd_idx_c;
    logic [2*CHOOSER_ENTRIES-1:0] chooser_flat_c;

    assign apply_c    = update_i.update_valid && update_i.is_branch;
    // Indexed like the local history table
    assign pred_idx_c = pc_i[CH_IDX_W+1:2];
    assign upd_idx_c  = update_i.update_pc[CH_IDX_W+1:2];

    assign use_global_o = chooser_r[pred_idx_c][1];

    //==================================================================
    // Training on disagreement
    //==================================================================

    // Agreeing opinions teach nothing about which one to trust
    assign train_c        = apply_c && (global_update_pred_i != local_update_pred_i);
    // On disagreement exactly one side matched
    assign global_right_c = (global_update_pred_i == update_i.actual_taken);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < CHOOSER_ENTRIES; i++) begin
                chooser_r[i] <= riscv_types_pkg::CNT_WEAK_LOCAL;
            end
        end else if (train_c) begin
            chooser_r[upd_idx_c] <= riscv_types_pkg::cnt_next(chooser_r[upd_idx_c],
                                                              global_right_c);
        end
    end

    always_comb begin
        for (int i = 0; i < CHOOSER_ENTRIES; i++) begin
            chooser_flat_c[2*i +: 2] = chooser_r[i];
        end
    end

    // Table frozen unless the predictors disagreed on the update PC
    a_move_on_disagree: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !train_c |=> $stable(chooser_flat_c));

    // Same PC on both ports must give both predictors the same answer
    a_ports_consistent: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (apply_c && (update_i.update_pc == pc_i)) |->
            (global_pred_i == global_update_pred_i) &&
            (local_pred_i == local_update_pred_i));

endmodule : tournament_chooser

// ==== branch_predictor.sv ====
//======================================================================
// Tournament branch predictor top
//======================================================================

`timescale 1ns/1ns

module branch_predictor #(
    parameter int GLOBAL_HISTORY_WIDTH = 8,
    parameter int PHT_ENTRIES          = 256,
    parameter int LOCAL_HISTORY_WIDTH  = 6,
    parameter int LHT_ENTRIES          = 64,
    parameter int CHOOSER_ENTRIES      = 64
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  riscv_types_pkg::addr_t          pc_i,
    input  riscv_types_pkg::branch_update_t update_i,
    output riscv_types_pkg::prediction_t    pred_o
);

    // Opinions for the lookup PC
    logic global_taken_c;
    logic local_taken_c;
    // Opinions for the update PC under pre-edge state
    logic global_upd_pred_c;
    logic local_upd_pred_c;
    logic use_global_c;

    //==================================================================
    // Component tables
    //==================================================================

    global_predictor #(
        .GLOBAL_HISTORY_WIDTH (GLOBAL_HISTORY_WIDTH),
        .PHT_ENTRIES          (PHT_ENTRIES)
    ) u_global (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .pc_i            (pc_i),
        .predict_taken_o (global_taken_c),
        .update_i        (update_i),
        .update_pred_o   (global_upd_pred_c)
    );

    local_predictor #(
        .LOCAL_HISTORY_WIDTH (LOCAL_HISTORY_WIDTH),
        .LHT_ENTRIES         (LHT_ENTRIES)
    ) u_local (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .pc_i            (pc_i),
        .predict_taken_o (local_taken_c),
        .update_i        (update_i),
        .update_pred_o   (local_upd_pred_c)
    );

    tournament_chooser #(
        .CHOOSER_ENTRIES (CHOOSER_ENTRIES)
    ) u_chooser (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .pc_i                 (pc_i),
        .update_i             (update_i),
        .global_pred_i        (global_taken_c),
        .local_pred_i         (local_taken_c),
        .global_update_pred_i (global_upd_pred_c),
        .local_update_pred_i  (local_upd_pred_c),
        .use_global_o         (use_global_c)
    );

    // Final pick is fully combinational from pc_i
    assign pred_o.taken       = use_global_c ? global_taken_c : local_taken_c;
    assign pred_o.used_global = use_global_c;

endmodule : branch_predictor

// ==== tb_clock_gen.sv ====
//======================================================================
// Testbench clock and reset
//======================================================================

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    // Extra reset request for mid-run resets
    input  logic soft_rst_i,
    output logic clk_o,
    output logic rst_no
);

    logic por_n;

    initial clk_o = 1'b0;
    always #(PERIOD_NS / 2) clk_o = ~clk_o;

    // Power-on reset released on a falling edge
    initial begin
        por_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        por_n = 1'b1;
    end

    assign rst_no = por_n && !soft_rst_i;

endmodule : tb_clock_gen

// ==== tb_branch_predictor.sv ====
//======================================================================
// Tournament branch predictor testbench
//======================================================================

`timescale 1ns/1ns

module tb_branch_predictor;

    localparam int GHW = 8;
    localparam int PHT_ENTRIES = 256;
    localparam int LHW = 6;
    localparam int LHT_ENTRIES = 64;
    localparam int CHOOSER_ENTRIES = 64;
    localparam int PHT_IDX_W = $clog2(PHT_ENTRIES);
    localparam int LHT_IDX_W = $clog2(LHT_ENTRIES);
    localparam int CH_IDX_W = $clog2(CHOOSER_ENTRIES);

    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES = 10;
    // Phase lengths in cycles
    localparam int IDLE_CYCLES = 64;
    localparam int TAKEN_TRAIN = 16;
    localparam int TAKEN_CHECK = 8;
    localparam int HOLD_CYCLES = 32;
    localparam int PAT_TRAIN = 36;
    localparam int PAT_CHECK = 9;
    localparam int RANDOM_CYCLES = 2000;
    localparam int RESET_PULSE = 3;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * IDLE_CYCLES + TAKEN_TRAIN + TAKEN_CHECK +
                                  HOLD_CYCLES + PAT_TRAIN + PAT_CHECK + RANDOM_CYCLES +
                                  RESET_PULSE + 4;
    // Twice the expected run length
    localparam int WATCHDOG_NS = 2 * TOTAL_CYCLES * CLK_PERIOD_NS;

    localparam logic [15:0] LFSR_SEED = 16'd1676;
    localparam riscv_types_pkg::addr_t PC_TAKEN = 32'h0000_1040;
    localparam riscv_types_pkg::addr_t PC_PATTERN = 32'h0000_2084;

    logic                            clk_i;
    logic                            rst_ni;
    logic                            soft_rst;
    riscv_types_pkg::addr_t          pc_i;
    riscv_types_pkg::branch_update_t update_i;
    riscv_types_pkg::prediction_t    pred_o;

    // Phase flags that enable the targeted checks
    logic check_reset_state;
    logic check_hold;
    logic check_taken;
    logic check_pattern;

    logic [15:0] lfsr_state;
    int          error_count;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .soft_rst_i (soft_rst),
        .clk_o      (clk_i),
        .rst_no     (rst_ni)
    );

    branch_predictor #(
        .GLOBAL_HISTORY_WIDTH (GHW),
        .PHT_ENTRIES          (PHT_ENTRIES),
        .LOCAL_HISTORY_WIDTH  (LHW),
        .LHT_ENTRIES          (LHT_ENTRIES),
        .CHOOSER_ENTRIES      (CHOOSER_ENTRIES)
    ) dut (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .pc_i     (pc_i),
        .update_i (update_i),
        .pred_o   (pred_o)
    );

    //==================================================================
    // Reference model
    //==================================================================

    logic [GHW-1:0]       m_ghr;
    logic [1:0]           m_pht  [PHT_ENTRIES];
    logic [LHW-1:0]       m_lht  [LHT_ENTRIES];
    logic [1:0]           m_lpht [1 << LHW];
    logic [1:0]           m_ch   [CHOOSER_ENTRIES];
    logic [PHT_IDX_W-1:0] m_lu_gidx;
    logic [PHT_IDX_W-1:0] m_up_gidx;
    logic [LHT_IDX_W-1:0] m_lu_lidx;
    logic [LHT_IDX_W-1:0] m_up_lidx;
    logic [CH_IDX_W-1:0]  m_lu_cidx;
    logic [CH_IDX_W-1:0]  m_up_cidx;
    logic [LHW-1:0]       m_up_hist;
    logic                 m_apply;
    logic                 m_g_ok;
    logic                 m_l_ok;
    riscv_types_pkg::prediction_t exp_pred_c;

    // Two-bit counter that sticks at 0 and 3
    function automatic logic [1:0] saturate_counter(input logic [1:0] c, input logic up);
        if (up && c != 2'b11) begin
            return c + 2'd1;
        end
        if (!up && c != 2'b00) begin
            return c - 2'd1;
        end
        return c;
    endfunction

    // Word address bits truncated to each table
    assign m_lu_gidx = PHT_IDX_W'(m_ghr) ^ PHT_IDX_W'(pc_i >> 2);
    assign m_up_gidx = PHT_IDX_W'(m_ghr) ^ PHT_IDX_W'(update_i.update_pc >> 2);
    assign m_lu_lidx = LHT_IDX_W'(pc_i >> 2);
    assign m_up_lidx = LHT_IDX_W'(update_i.update_pc >> 2);
    assign m_lu_cidx = CH_IDX_W'(pc_i >> 2);
    assign m_up_cidx = CH_IDX_W'(update_i.update_pc >> 2);
    assign m_up_hist = m_lht[m_up_lidx];
    assign m_apply   = update_i.update_valid && update_i.is_branch;
    assign m_g_ok    = (m_pht[m_up_gidx][1] == update_i.actual_taken);
    assign m_l_ok    = (m_lpht[m_up_hist][1] == update_i.actual_taken);

    always_comb begin
        exp_pred_c.used_global = m_ch[m_lu_cidx][1];
        if (m_ch[m_lu_cidx][1]) begin
            exp_pred_c.taken = m_pht[m_lu_gidx][1];
        end else begin
            exp_pred_c.taken = m_lpht[m_lht[m_lu_lidx]][1];
        end
    end

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            m_ghr <= '0;
            for (int i = 0; i < PHT_ENTRIES; i++) m_pht[i] <= 2'b01;
            for (int i = 0; i < LHT_ENTRIES; i++) m_lht[i] <= '0;
            for (int i = 0; i < (1 << LHW); i++) m_lpht[i] <= 2'b01;
            for (int i = 0; i < CHOOSER_ENTRIES; i++) m_ch[i] <= 2'b01;
        end else if (m_apply) begin
            m_ghr <= GHW'({m_ghr, update_i.actual_taken});
            m_pht[m_up_gidx] <= saturate_counter(m_pht[m_up_gidx], update_i.actual_taken);
            m_lpht[m_up_hist] <= saturate_counter(m_lpht[m_up_hist], update_i.actual_taken);
            m_lht[m_up_lidx] <= LHW'({m_up_hist, update_i.actual_taken});
            // Chooser learns only when exactly one side was right
            if (m_g_ok != m_l_ok) begin
                m_ch[m_up_cidx] <= saturate_counter(m_ch[m_up_cidx], m_g_ok);
            end
        end
    end

    //==================================================================
    // Failure reporting and checks
    //==================================================================

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    a_model_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pred_o == exp_pred_c)
        else report_mismatch($sformatf("pred_o %b differs from model %b for pc %h",
                                       $sampled(pred_o), $sampled(exp_pred_c),
                                       $sampled(pc_i)));

    a_reset_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
        check_reset_state |-> (pred_o == '0))
        else report_mismatch("prediction after reset is not clear");

    // Non-applied updates with a steady pc
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (check_hold && $past(check_hold)) |-> $stable(pred_o))
        else report_mismatch("prediction moved without an applied update");

    a_always_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
        check_taken |-> pred_o.taken)
        else report_mismatch("always-taken branch not predicted taken");

    a_pattern: assert property (@(posedge clk_i) disable iff (!rst_ni)
        check_pattern |-> (pred_o.taken == update_i.actual_taken))
        else report_mismatch("repeating pattern mispredicted after training");

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    //==================================================================
    // Stimulus
    //==================================================================

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int n, output logic [31:0] value);
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            acc = {acc[30:0], lfsr_state[0]};
        end
        value = acc;
    endtask

    task automatic drive_update(input riscv_types_pkg::addr_t upc, input logic valid,
                                input logic branch, input logic taken);
        update_i.update_valid = valid;
        update_i.is_branch    = branch;
        update_i.actual_taken = taken;
        update_i.update_pc    = upc;
    endtask

    // New cycle at the falling edge with all flags low
    task automatic next_cycle();
        @(negedge clk_i);
        check_reset_state = 1'b0;
        check_hold        = 1'b0;
        check_taken       = 1'b0;
        check_pattern     = 1'b0;
    endtask

    task automatic sweep_idle_lookups();
        logic [31:0] r;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            next_cycle();
            random_bits(30, r);
            pc_i = {r[29:0], 2'b00};
            drive_update('0, 1'b0, 1'b0, 1'b0);
            check_reset_state = 1'b1;
        end
    endtask

    task automatic train_always_taken();
        for (int i = 0; i < TAKEN_TRAIN + TAKEN_CHECK; i++) begin
            next_cycle();
            pc_i = PC_TAKEN;
            drive_update(PC_TAKEN, 1'b1, 1'b1, 1'b1);
            check_taken = (i >= TAKEN_TRAIN);
        end
    endtask

    task automatic hold_without_update();
        logic [31:0] kind;
        logic [31:0] r;
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            next_cycle();
            random_bits(2, kind);
            random_bits(9, r);
            pc_i = PC_TAKEN;
            // Either the strobe or the branch flag is low
            if (kind[0]) begin
                drive_update({22'd0, r[7:0], 2'b00}, 1'b0, kind[1], r[8]);
            end else begin
                drive_update({22'd0, r[7:0], 2'b00}, 1'b1, 1'b0, r[8]);
            end
            check_hold = 1'b1;
        end
    endtask

    task automatic train_repeating_pattern();
        for (int i = 0; i < PAT_TRAIN + PAT_CHECK; i++) begin
            next_cycle();
            pc_i = PC_PATTERN;
            // Taken, taken, not taken
            drive_update(PC_PATTERN, 1'b1, 1'b1, (i % 3) != 2);
            check_pattern = (i >= PAT_TRAIN);
        end
    endtask

    task automatic mix_random_updates();
        logic [31:0] r;
        riscv_types_pkg::addr_t upc;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            next_cycle();
            random_bits(8, r);
            upc = 32'h0000_4000 + {22'd0, r[7:0], 2'b00};
            random_bits(7, r);
            drive_update(upc, r[2:0] != 3'd0, r[5:3] != 3'd0, r[6]);
            random_bits(9, r);
            // Half the lookups hit the PC being trained
            pc_i = r[8] ? upc : 32'h0000_4000 + {22'd0, r[7:0], 2'b00};
        end
    endtask

    task automatic pulse_mid_reset();
        next_cycle();
        drive_update('0, 1'b0, 1'b0, 1'b0);
        soft_rst = 1'b1;
        repeat (RESET_PULSE) @(negedge clk_i);
        soft_rst = 1'b0;
    endtask

    initial begin
        pc_i              = '0;
        update_i          = '0;
        soft_rst          = 1'b0;
        check_reset_state = 1'b0;
        check_hold        = 1'b0;
        check_taken       = 1'b0;
        check_pattern     = 1'b0;
        lfsr_state        = LFSR_SEED;
        error_count       = 0;
        wait (rst_ni === 1'b1);
        sweep_idle_lookups();
        train_always_taken();
        hold_without_update();
        train_repeating_pattern();
        mix_random_updates();
        pulse_mid_reset();
        sweep_idle_lookups();
        // Let the last drive reach a rising edge
        next_cycle();
        drive_update('0, 1'b0, 1'b0, 1'b0);
        @(negedge clk_i);
        if (error_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule : tb_branch_predictor

// ==== build.f ====
riscv_types_pkg.sv
global_predictor.sv
local_predictor.sv
tournament_chooser.sv
branch_predictor.sv
tb_clock_gen.sv
tb_branch_predictor.sv

// ==== Makefile ====
# Verilator flow for the tournament branch predictor

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_branch_predictor
RTL_TOP   ?= branch_predictor
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --timing --assert --timescale 1ns/1ns

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# Pass or fail comes from the log, not the exit code
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
